// ==== sim.f ====
+incdir+include
hdl/match_pkg.sv
hdl/match_ifs.sv
hdl/char_decode.sv
hdl/dfa_execute.sv
hdl/match_result.sv
hdl/regex_csr.sv
hdl/regex_matcher_top.sv
test/tb_regex_matcher.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the regex matcher testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_regex_matcher -o tb_sim

if ! ./obj_dir/tb_sim > sim.log 2>&1; then
  cat sim.log
  exit 1
fi
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
  exit 0
fi
exit 1

// ==== test/tb_regex_matcher.sv ====
`include "match_defs.svh"

module tb_regex_matcher;

  localparam int MAX_LEN = 12;
  localparam int NUM_T3 = 20;
  localparam int NUM_T5 = 200;
  // Worst case per packet is a gap before every byte, the load and three idle cycles
  localparam int PKT_CYCLES = 2 * MAX_LEN + 4;
  localparam int NUM_PKTS = NUM_T3 + 4 + NUM_T5;

  // Reference DFA states
  localparam int M_IDLE = 0;
  localparam int M_S = 1;
  localparam int M_SM = 2;
  localparam int M_HIT = 3;

  typedef logic [`MATCH_BYTE_W-1:0] payload_t [$];

  logic                     clk;
  logic                     rst_n;
  logic [`MATCH_BYTE_W-1:0] char_in;
  logic                     char_vld;
  logic                     load_state;
  logic                     new_stream;
  logic [`MATCH_ID_W-1:0]   stream_id;
  logic                     eop;
  logic                     fired;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [`MATCH_ADR_W-1:0]  wb_adr;
  logic [`MATCH_DAT_W-1:0]  wb_dat_i;
  logic [`MATCH_DAT_W-1:0]  wb_dat_o;
  logic                     wb_ack;

  // Reference model state
  int                        ctx [`MATCH_STREAMS];
  bit                        seen [`MATCH_STREAMS];
  logic [`MATCH_STREAMS-1:0] mask;
  logic [`MATCH_CNT_W-1:0]   mcount;
  logic [`MATCH_CNT_W-1:0]   pcount;
  // Expected fired values on their way through the 3-cycle latency
  bit                        exp_vld [3];
  bit                        exp_val [3];
  int                        errors;
  int                        errors_base;
  int                        tests_run;
  int                        tests_failed;

  regex_matcher_top u_regex_matcher_top (.*);

  always #5 clk = ~clk;

  // Reference DFA for "SMB"
  function automatic int next_state(int st, logic [`MATCH_BYTE_W-1:0] b);
    if (b == "S")
      return M_S;
    if (b == "M" && st == M_S)
      return M_SM;
    if (b == "B" && st == M_SM)
      return M_HIT;
    return M_IDLE;
  endfunction

  // Bytes leaning toward the pattern letters so matches are common
  function automatic payload_t random_payload(int len);
    payload_t q;
    for (int i = 0; i < len; i++)
    begin
      case ($urandom_range(7, 0))
        0, 1:    q.push_back("S");
        2, 3:    q.push_back("M");
        4, 5:    q.push_back("B");
        default: q.push_back(`MATCH_BYTE_W'($urandom()));
      endcase
    end
    return q;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
    assert (got === want)
    else
    begin
      errors++;
      $display("ERROR t=%0t %s: got 0x%0h expected 0x%0h", $time, name, got, want);
    end
  endtask

  // One clock; compares fired for the byte driven three falling edges ago
  task automatic advance_cycle(bit vld, bit val);
    @(negedge clk);
    exp_vld[2] = exp_vld[1];
    exp_val[2] = exp_val[1];
    exp_vld[1] = exp_vld[0];
    exp_val[1] = exp_val[0];
    exp_vld[0] = vld;
    exp_val[0] = val;
    if (exp_vld[2])
      check_value("fired", {31'd0, fired}, {31'd0, exp_val[2]});
  endtask

  // Single Wishbone classic access with the ack expected one cycle after the request
  // Strobe stays up through the clock edge that samples the ack
  task automatic bus_access(logic [`MATCH_ADR_W-1:0] adr, bit we, logic [31:0] wdata,
                            output logic [31:0] rdata);
    int lat;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_i = wdata;
    lat = 0;
    do
    begin
      @(negedge clk);
      lat++;
    end while (!wb_ack && lat < 8);
    assert (wb_ack)
    else
    begin
      errors++;
      $display("Wishbone access to offset 0x%0h was never acknowledged", adr);
    end
    check_value("wb_ack latency", lat, 32'd1);
    rdata = wb_dat_o;
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    @(negedge clk);
  endtask

  task automatic expect_reg(logic [`MATCH_ADR_W-1:0] adr, logic [31:0] want, string name);
    logic [31:0] rd;
    bus_access(adr, 1'b0, 32'd0, rd);
    check_value(name, rd, want);
  endtask

  task automatic write_mask(logic [31:0] lo, logic [31:0] hi);
    logic [31:0] rd;
    bus_access(`MATCH_REG_ENA_LO, 1'b1, lo, rd);
    bus_access(`MATCH_REG_ENA_HI, 1'b1, hi, rd);
    mask = {hi, lo};
  endtask

  // Load, bytes with random gaps, then the idle gap that lets the save land
  task automatic send_packet(int sid, payload_t data);
    int st;
    bit flag;
    bit en;
    bit is_new;
    is_new = !seen[sid];
    stream_id = `MATCH_ID_W'(sid);
    new_stream = is_new;
    load_state = 1'b1;
    advance_cycle(1'b0, 1'b0);
    load_state = 1'b0;
    new_stream = 1'b0;
    st = is_new ? M_IDLE : ctx[sid];
    en = mask[sid];
    flag = 1'b0;
    foreach (data[i])
    begin
      if ($urandom_range(3, 0) == 0)
        advance_cycle(1'b0, 1'b0);
      st = next_state(st, data[i]);
      flag = flag || (st == M_HIT);
      char_in = data[i];
      char_vld = 1'b1;
      eop = (i == data.size() - 1);
      advance_cycle(1'b1, flag);
      char_vld = 1'b0;
      eop = 1'b0;
    end
    pcount = pcount + `MATCH_CNT_W'(1);
    // Disabled streams neither count nor keep their state
    if (en)
    begin
      mcount = mcount + `MATCH_CNT_W'(flag);
      ctx[sid] = st;
    end
    seen[sid] = 1'b1;
    repeat (3) advance_cycle(1'b0, 1'b0);
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (errors != errors_base)
      tests_failed++;
    $display("Test %0d %s: %s", tests_run, name, (errors == errors_base) ? "ok" : "failed");
    errors_base = errors;
  endtask

  initial
  begin
    logic [31:0] rd;
    logic [31:0] lo;
    logic [31:0] hi;
    payload_t pkt;
    void'($urandom(32'h3277));
    clk = 1'b0;
    rst_n = 1'b0;
    char_in = '0;
    char_vld = 1'b0;
    load_state = 1'b0;
    new_stream = 1'b0;
    stream_id = '0;
    eop = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_i = '0;
    mask = '0;
    mcount = '0;
    pcount = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    expect_reg(`MATCH_REG_ENA_LO, 32'd0, "ENA_LO");
    expect_reg(`MATCH_REG_ENA_HI, 32'd0, "ENA_HI");
    expect_reg(`MATCH_REG_MCOUNT, 32'd0, "MCOUNT");
    expect_reg(`MATCH_REG_PCOUNT, 32'd0, "PCOUNT");
    end_test("reset values");

    repeat (8)
    begin
      lo = $urandom();
      hi = $urandom();
      write_mask(lo, hi);
      expect_reg(`MATCH_REG_ENA_LO, lo, "ENA_LO");
      expect_reg(`MATCH_REG_ENA_HI, hi, "ENA_HI");
    end
    end_test("enable mask read-back");

    // New enabled streams only
    write_mask(32'hFFFF_FFFF, 32'hFFFF_FFFF);
    for (int i = 0; i < NUM_T3; i++)
      send_packet(i, random_payload($urandom_range(MAX_LEN, 1)));
    end_test("single-packet fired");

    // Stream 40 enabled, stream 41 disabled, "SM" then "B" on each
    write_mask(32'hFFFF_FFFF, 32'h0000_0100);
    bus_access(`MATCH_REG_MCOUNT, 1'b1, 32'd0, rd);
    mcount = '0;
    for (int sid = 40; sid < 42; sid++)
    begin
      pkt.delete();
      pkt.push_back("S");
      pkt.push_back("M");
      send_packet(sid, pkt);
      pkt.delete();
      pkt.push_back("B");
      send_packet(sid, pkt);
      expect_reg(`MATCH_REG_MCOUNT, 32'd1, "MCOUNT after split pattern");
    end
    expect_reg(`MATCH_REG_PCOUNT, `MATCH_DAT_W'(pcount), "PCOUNT");
    end_test("cross-packet match");

    write_mask($urandom(), $urandom());
    for (int i = 0; i < NUM_T5; i++)
      send_packet($urandom_range(`MATCH_STREAMS - 1, 0),
                  random_payload($urandom_range(MAX_LEN, 1)));
    expect_reg(`MATCH_REG_MCOUNT, `MATCH_DAT_W'(mcount), "MCOUNT");
    expect_reg(`MATCH_REG_PCOUNT, `MATCH_DAT_W'(pcount), "PCOUNT");
    // Writing MCOUNT clears only the match count
    bus_access(`MATCH_REG_MCOUNT, 1'b1, 32'd0, rd);
    mcount = '0;
    expect_reg(`MATCH_REG_MCOUNT, 32'd0, "MCOUNT after clear");
    expect_reg(`MATCH_REG_PCOUNT, `MATCH_DAT_W'(pcount), "PCOUNT after clear");
    end_test("interleaved counting");

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // Watchdog sized from the longest possible packets plus bus traffic
  initial
  begin
    longint budget;
    budget = longint'(NUM_PKTS * PKT_CYCLES + 500) * 10;
    #(budget);
    $display("Timeout: the run did not finish within %0d time units", budget);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== hdl/regex_matcher_top.sv ====
`include "match_defs.svh"

module regex_matcher_top (
  input  logic                     clk,
  input  logic                     rst_n,
  // Packet side
  input  logic [`MATCH_BYTE_W-1:0] char_in,
  input  logic                     char_vld,
  input  logic                     load_state,
  input  logic                     new_stream,
  input  logic [`MATCH_ID_W-1:0]   stream_id,
  input  logic                     eop,
  output logic                     fired,
  // Wishbone side
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`MATCH_ADR_W-1:0]  wb_adr,
  input  logic [`MATCH_DAT_W-1:0]  wb_dat_i,
  output logic [`MATCH_DAT_W-1:0]  wb_dat_o,
  output logic                     wb_ack
);

  dfa_step_if   step_bus ();
  dfa_result_if res_bus ();

  // Context save path back to decode
  logic                      save_vld;
  logic [`MATCH_ID_W-1:0]    save_id;
  match_pkg::dfa_state_e     save_state;
  logic [`MATCH_STREAMS-1:0] enable_mask;
  logic [`MATCH_CNT_W-1:0]   match_count;
  logic [`MATCH_CNT_W-1:0]   pkt_count;
  logic                      clr_mcount;

  char_decode u_char_decode (
    .clk(clk), .rst_n(rst_n), .char_in(char_in), .char_vld(char_vld),
    .load_state(load_state), .new_stream(new_stream), .stream_id(stream_id), .eop(eop),
    .enable_mask(enable_mask), .save_vld(save_vld), .save_id(save_id),
    .save_state(save_state), .step(step_bus)
  );

  dfa_execute u_dfa_execute (.clk(clk), .rst_n(rst_n), .step(step_bus), .res(res_bus));

  match_result u_match_result (
    .clk(clk), .rst_n(rst_n), .res(res_bus), .clr_mcount(clr_mcount), .fired(fired),
    .save_vld(save_vld), .save_id(save_id), .save_state(save_state),
    .match_count(match_count), .pkt_count(pkt_count)
  );

  regex_csr u_regex_csr (
    .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .match_count(match_count), .pkt_count(pkt_count),
    .wb_dat_o(wb_dat_o), .wb_ack(wb_ack), .enable_mask(enable_mask), .clr_mcount(clr_mcount)
  );

endmodule

// ==== hdl/regex_csr.sv ====
`include "match_defs.svh"

module regex_csr (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [`MATCH_ADR_W-1:0]   wb_adr,
  input  logic [`MATCH_DAT_W-1:0]   wb_dat_i,
  input  logic [`MATCH_CNT_W-1:0]   match_count,
  input  logic [`MATCH_CNT_W-1:0]   pkt_count,
  output logic [`MATCH_DAT_W-1:0]   wb_dat_o,
  output logic                      wb_ack,
  output logic [`MATCH_STREAMS-1:0] enable_mask,
  output logic                      clr_mcount
);

  match_pkg::csr_sel_e sel;
  logic [`MATCH_DAT_W-1:0] rd_data;
  // Set after an ack until the master drops stb
  logic held;
  logic req_new;

  assign req_new = wb_cyc && wb_stb && !wb_ack && !held;

  // Address decode
  // Unmapped offsets fall on the read-only packet counter
  always_comb
  begin
    case (wb_adr)
      `MATCH_REG_ENA_LO: sel = match_pkg::SEL_ENA_LO;
      `MATCH_REG_ENA_HI: sel = match_pkg::SEL_ENA_HI;
      `MATCH_REG_MCOUNT: sel = match_pkg::SEL_MCOUNT;
      default:           sel = match_pkg::SEL_PCOUNT;
    endcase
  end

  always_comb
  begin
    case (sel)
      match_pkg::SEL_ENA_LO: rd_data = enable_mask[`MATCH_DAT_W-1:0];
      match_pkg::SEL_ENA_HI: rd_data = enable_mask[`MATCH_STREAMS-1:`MATCH_DAT_W];
      match_pkg::SEL_MCOUNT: rd_data = `MATCH_DAT_W'(match_count);
      default:               rd_data = `MATCH_DAT_W'(pkt_count);
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wb_ack      <= 1'b0;
      held        <= 1'b0;
      clr_mcount  <= 1'b0;
      enable_mask <= '0;
    end
    else
    begin
      wb_ack     <= req_new;
      held       <= wb_stb && (held || wb_ack);
      // Any write to MCOUNT clears it
      clr_mcount <= req_new && wb_we && (sel == match_pkg::SEL_MCOUNT);
      if (req_new && wb_we && sel == match_pkg::SEL_ENA_LO)
        enable_mask[`MATCH_DAT_W-1:0] <= wb_dat_i;
      if (req_new && wb_we && sel == match_pkg::SEL_ENA_HI)
        enable_mask[`MATCH_STREAMS-1:`MATCH_DAT_W] <= wb_dat_i;
    end
  end

  // Read data lands together with the ack
  always_ff @(posedge clk)
  begin
    if (req_new && !wb_we)
      wb_dat_o <= rd_data;
  end

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> (wb_cyc && wb_stb));

endmodule

// ==== hdl/match_result.sv ====
`include "match_defs.svh"

module match_result (
  input  logic                    clk,
  input  logic                    rst_n,
  dfa_result_if.snk               res,
  input  logic                    clr_mcount,
  output logic                    fired,
  output logic                    save_vld,
  output logic [`MATCH_ID_W-1:0]  save_id,
  output match_pkg::dfa_state_e   save_state,
  output logic [`MATCH_CNT_W-1:0] match_count,
  output logic [`MATCH_CNT_W-1:0] pkt_count
);

  logic load_cue;
  logic end_item;
  logic pkt_hit;

  // Start of packet marker from the execute stage
  assign load_cue = !res.vld && res.last;
  assign end_item = res.vld && res.last;
  // Sticky flag plus the byte now ending the packet
  assign pkt_hit  = fired || res.hit;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      fired       <= 1'b0;
      save_vld    <= 1'b0;
      match_count <= '0;
      pkt_count   <= '0;
    end
    else
    begin
      save_vld <= end_item && res.enable;

      // Per-packet match flag
      if (load_cue)
        fired <= 1'b0;
      else if (res.vld && res.hit)
        fired <= 1'b1;

      // Every finished packet is counted, enabled or not
      if (end_item)
        pkt_count <= pkt_count + 1'b1;

      // Host clear wins over a same-cycle increment
      if (clr_mcount)
        match_count <= '0;
      else if (end_item && res.enable)
        match_count <= match_count + `MATCH_CNT_W'(pkt_hit);
    end
  end

  // Context to save, captured with the last byte
  always_ff @(posedge clk)
  begin
    if (end_item)
    begin
      save_id    <= res.stream_id;
      save_state <= res.state;
    end
  end

  a_save_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    save_vld |=> !save_vld);

endmodule

// ==== hdl/dfa_execute.sv ====
module dfa_execute (
  input  logic       clk,
  input  logic       rst_n,
  dfa_step_if.snk    step,
  dfa_result_if.src  res
);

  match_pkg::dfa_state_e cur_state;
  match_pkg::dfa_state_e nxt_state;

  // Transition function for "SMB"
  always_comb
  begin
    case (step.byte_cls)
      // An S always restarts the pattern
      match_pkg::CLS_S:
        nxt_state = match_pkg::ST_S;
      match_pkg::CLS_M:
        nxt_state = (cur_state == match_pkg::ST_S) ? match_pkg::ST_SM : match_pkg::ST_IDLE;
      match_pkg::CLS_B:
        nxt_state = (cur_state == match_pkg::ST_SM) ? match_pkg::ST_HIT : match_pkg::ST_IDLE;
      default:
        nxt_state = match_pkg::ST_IDLE;
    endcase
  end

  // Running state; a load overwrites it
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      cur_state <= match_pkg::ST_IDLE;
    else if (step.load)
      cur_state <= step.load_state;
    else if (step.vld)
      cur_state <= nxt_state;
  end

  // Result item, one cycle behind the step
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      res.vld  <= 1'b0;
      res.last <= 1'b0;
    end
    else
    begin
      res.vld <= step.vld;
      // Load shows up as last without vld
      res.last <= step.vld ? step.last : step.load;
    end
  end

  always_ff @(posedge clk)
  begin
    res.hit       <= (nxt_state == match_pkg::ST_HIT);
    res.state     <= nxt_state;
    res.enable    <= step.enable;
    res.stream_id <= step.stream_id;
  end

  a_no_byte_with_load: assert property (@(posedge clk) disable iff (!rst_n)
    !(step.vld && step.load));

endmodule

// ==== hdl/char_decode.sv ====
`include "match_defs.svh"

module char_decode (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`MATCH_BYTE_W-1:0]  char_in,
  input  logic                      char_vld,
  input  logic                      load_state,
  input  logic                      new_stream,
  input  logic [`MATCH_ID_W-1:0]    stream_id,
  input  logic                      eop,
  input  logic [`MATCH_STREAMS-1:0] enable_mask,
  input  logic                      save_vld,
  input  logic [`MATCH_ID_W-1:0]    save_id,
  input  match_pkg::dfa_state_e     save_state,
  dfa_step_if.src                   step
);

  // Saved DFA state, one entry per stream
  match_pkg::dfa_state_e ctx_mem [`MATCH_STREAMS];
  match_pkg::byte_class_e cls;

  // Byte classifier
  always_comb
  begin
    case (char_in)
      "S":     cls = match_pkg::CLS_S;
      "M":     cls = match_pkg::CLS_M;
      "B":     cls = match_pkg::CLS_B;
      default: cls = match_pkg::CLS_OTHER;
    endcase
  end

  // Context write-back from the result stage
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `MATCH_STREAMS; i++)
        ctx_mem[i] <= match_pkg::ST_IDLE;
    end
    else if (save_vld)
      ctx_mem[save_id] <= save_state;
  end

  // Valid flags of the step item
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      step.vld  <= 1'b0;
      step.last <= 1'b0;
      step.load <= 1'b0;
    end
    else
    begin
      step.vld  <= char_vld;
      step.last <= char_vld && eop;
      step.load <= load_state;
    end
  end

  // Payload; stream id and enable bit are latched only at the load
  always_ff @(posedge clk)
  begin
    step.byte_cls <= cls;
    if (load_state)
    begin
      // New streams start from idle, old ones resume the saved state
      step.load_state <= new_stream ? match_pkg::ST_IDLE : ctx_mem[stream_id];
      step.enable     <= enable_mask[stream_id];
      step.stream_id  <= stream_id;
    end
  end

  // Three idle cycles after eop keep the save ahead of any reload
  a_eop_gap: assert property (@(posedge clk) disable iff (!rst_n)
    (char_vld && eop) |=> !load_state [*3]);

  a_no_byte_on_load: assert property (@(posedge clk) disable iff (!rst_n)
    !(char_vld && load_state));

endmodule

// ==== hdl/match_ifs.sv ====
`include "match_defs.svh"

// Decode to execute; one byte or one context load per cycle
interface dfa_step_if;
  logic                    vld;
  match_pkg::byte_class_e  byte_cls;
  logic                    last;
  logic                    load;
  match_pkg::dfa_state_e   load_state;
  // Held from the load for the whole packet
  logic                    enable;
  logic [`MATCH_ID_W-1:0]  stream_id;

  modport src (output vld, byte_cls, last, load, load_state, enable, stream_id);
  modport snk (input vld, byte_cls, last, load, load_state, enable, stream_id);
endinterface

// Execute to result
// last without vld is the start-of-packet cue that follows a load
interface dfa_result_if;
  logic                    vld;
  logic                    hit;
  logic                    last;
  logic                    enable;
  logic [`MATCH_ID_W-1:0]  stream_id;
  match_pkg::dfa_state_e   state;

  modport src (output vld, hit, last, enable, stream_id, state);
  modport snk (input vld, hit, last, enable, stream_id, state);
endinterface

// ==== hdl/match_pkg.sv ====
package match_pkg;

  // DFA for the string "SMB"
  // ST_HIT means the last byte completed the pattern
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_S    = 2'd1,
    ST_SM   = 2'd2,
    ST_HIT  = 2'd3
  } dfa_state_e;

  // Decoded opcode of one payload byte
  typedef enum logic [1:0] {
    CLS_S     = 2'd0,
    CLS_M     = 2'd1,
    CLS_B     = 2'd2,
    CLS_OTHER = 2'd3
  } byte_class_e;

  // Register selected by the Wishbone address
  typedef enum logic [1:0] {
    SEL_ENA_LO = 2'd0,
    SEL_ENA_HI = 2'd1,
    SEL_MCOUNT = 2'd2,
    SEL_PCOUNT = 2'd3
  } csr_sel_e;

endpackage

// ==== include/match_defs.svh ====
`ifndef MATCH_DEFS_SVH
`define MATCH_DEFS_SVH

// Stream context sizing
`define MATCH_STREAMS 64
`define MATCH_ID_W 6
`define MATCH_BYTE_W 8
`define MATCH_CNT_W 16

// Wishbone bus widths
`define MATCH_ADR_W 4
`define MATCH_DAT_W 32

// Register byte offsets
`define MATCH_REG_ENA_LO 4'h0
`define MATCH_REG_ENA_HI 4'h4
`define MATCH_REG_MCOUNT 4'h8
`define MATCH_REG_PCOUNT 4'hC

`endif
